//--- all.f
src/dsm_pkg.sv
src/status_pkg.sv
src/fifo_status_if.sv
src/dsm_poll_reader.sv
src/fifo_credit_tracker.sv
src/dsm_write_sequencer.sv
src/status_manager_top.sv
+incdir+tests
tests/tb_status_manager.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the status manager testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_status_manager -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

//--- tests/tb_status_model.svh
// Reference functions for expected DSM line addresses, line contents and pointer write decisions
`ifndef TB_STATUS_MODEL_SVH
`define TB_STATUS_MODEL_SVH

// Each DSM slot sits at a fixed line offset from the base
function automatic logic [31:0] expected_addr(input logic [31:0] base, input int ofs);
    return base + 32'(ofs);
endfunction

// Line 0 holds the device ID, then the largest index of each FIFO
function automatic logic [511:0] device_id_line();
    logic [511:0] line;
    line = '0;
    line[127:0]   = DEVICE_ID;
    line[159:128] = 32'((1 << FH_BITS) - 1);
    line[191:160] = 32'((1 << TH_BITS) - 1);
    return line;
endfunction

// Line 1 carries the 64-bit response and a landed flag in the top bit
function automatic logic [511:0] sreg_line(input logic [63:0] rsp);
    logic [511:0] line;
    line = '0;
    line[63:0] = rsp;
    line[511]  = 1'b1;
    return line;
endfunction

// Debug source chosen by the dump index
function automatic logic [31:0] debug_source(input logic [2:0] idx, input logic [31:0] fh,
                                             input logic [31:0] th, input logic [31:0] tester,
                                             input logic [FH_BITS-1:0] newest,
                                             input logic [TH_BITS-1:0] oldest);
    case (idx)
        3'd1: return fh;
        3'd2: return th;
        3'd3: return tester;
        // Polled pointers with the newest in the low half
        3'd4: return {16'(oldest), 16'(newest)};
        default: return 32'h0;
    endcase
endfunction

// Line 2 is the index in word 0 and the selected word in word 1
function automatic logic [511:0] debug_line(input logic [2:0] idx, input logic [31:0] word);
    logic [511:0] line;
    line = '0;
    line[31:0]  = 32'(idx);
    line[63:32] = word;
    return line;
endfunction

// Line 3 is the from-host pointer in word 0 and the to-host pointer in word 1
function automatic logic [511:0] fifo_line(input logic [FH_BITS-1:0] from_ptr,
                                           input logic [TH_BITS-1:0] to_ptr);
    logic [511:0] line;
    line = '0;
    line[31:0]  = 32'(from_ptr);
    line[63:32] = 32'(to_ptr);
    return line;
endfunction

// Any to-host move, or a flip of the watched from-host bit, needs a write
function automatic logic fifo_write_due(input logic [FH_BITS-1:0] from_ptr,
                                        input logic [TH_BITS-1:0] to_ptr,
                                        input logic [FH_BITS-1:0] last_from,
                                        input logic [TH_BITS-1:0] last_to);
    return (to_ptr != last_to) || (from_ptr[FH_BITS-3] != last_from[FH_BITS-3]);
endfunction

`endif

//--- tests/tb_status_manager.sv
// Status manager testbench with clock, reset, LFSR stimulus, arbiter model, compare process and watchdog
`timescale 1ns/10ps

module tb_status_manager
    import dsm_pkg::*, status_pkg::*;
();

    localparam int FH_BITS         = 9;
    localparam int TH_BITS         = 9;
    localparam int CLK_PERIOD      = 4;
    localparam int NUM_PTR_MOVES   = 24;
    localparam int NUM_DEBUG_IDX   = 4;
    localparam int NUM_SREG_RSPS   = 4;
    localparam int NUM_TEST_STARTS = 2;
    // The device ID line, pointer moves, debug dumps, status responses and test starts
    localparam int NUM_TESTS = 1 + NUM_PTR_MOVES + NUM_DEBUG_IDX + NUM_SREG_RSPS +
                               NUM_TEST_STARTS;
    // Each test needs at most about 64 cycles including the longest grant delay
    localparam int WATCHDOG_NS = NUM_TESTS * 64 * CLK_PERIOD + 4000;
    localparam logic [31:0] BASE = 32'h0001_2340;

    logic clk;
    logic resetb;
    t_line_addr dsm_base;
    logic dsm_base_valid;
    logic enable_test;
    t_debug_idx debug_trigger;
    logic sreg_rsp_valid;
    logic [63:0] sreg_rsp;
    t_debug_word dbg_from_host;
    t_debug_word dbg_to_host;
    t_debug_word dbg_tester;
    logic [FH_BITS-1:0] from_host_oldest_read;
    logic [TH_BITS-1:0] to_host_next_write;
    logic rd_req;
    t_line_addr rd_addr;
    t_read_tag rd_out_tag;
    logic rd_grant;
    logic rd_valid;
    t_read_tag rd_tag;
    t_line rd_data;
    logic wr_req;
    t_line_addr wr_addr;
    t_line wr_data;
    logic wr_grant;
    logic [FH_BITS-1:0] polled_newest;
    logic [TH_BITS-1:0] polled_oldest;

    // Expected write for the compare process, and bookkeeping
    t_line_addr exp_addr;
    t_line exp_line;
    logic [FH_BITS-1:0] last_newest;
    logic [TH_BITS-1:0] last_oldest;
    logic rd_hold;
    logic [15:0] lfsr;
    int mismatches;
    int other_errors;
    int writes_checked;
    int polls_checked;

    `include "tb_status_model.svh"

    status_manager_top #(
        .FROM_HOST_IDX_BITS (FH_BITS),
        .TO_HOST_IDX_BITS   (TH_BITS)
    ) dut_i (
        .clk                   (clk),
        .resetb                (resetb),
        .dsm_base              (dsm_base),
        .dsm_base_valid        (dsm_base_valid),
        .enable_test           (enable_test),
        .debug_trigger         (debug_trigger),
        .sreg_rsp_valid        (sreg_rsp_valid),
        .sreg_rsp              (sreg_rsp),
        .dbg_from_host         (dbg_from_host),
        .dbg_to_host           (dbg_to_host),
        .dbg_tester            (dbg_tester),
        .from_host_oldest_read (from_host_oldest_read),
        .to_host_next_write    (to_host_next_write),
        .rd_req                (rd_req),
        .rd_addr               (rd_addr),
        .rd_out_tag            (rd_out_tag),
        .rd_grant              (rd_grant),
        .rd_valid              (rd_valid),
        .rd_tag                (rd_tag),
        .rd_data               (rd_data),
        .wr_req                (wr_req),
        .wr_addr               (wr_addr),
        .wr_data               (wr_data),
        .wr_grant              (wr_grant),
        .polled_newest         (polled_newest),
        .polled_oldest         (polled_oldest)
    );

    // Fibonacci LFSR with taps for x^16 + x^14 + x^13 + x^11 that steps once per bit taken
    function logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ======================================================================
    // Arbiter and host memory model
    // ======================================================================

    // Wait for a write request, grant it after a random delay
    task automatic grant_write(input t_line_addr addr, input t_line line);
        int delay;
        int waited;
        exp_addr = addr;
        exp_line = line;
        waited = 0;
        @(negedge clk);
        while (!wr_req && waited < 30)
        begin
            @(negedge clk);
            waited++;
        end
        if (!wr_req)
        begin
            $display("No write request for line address %h arrived within 30 cycles at %0t",
                     addr, $time);
            other_errors++;
        end
        else
        begin
            delay = int'(take_bits(3));
            repeat (delay) @(posedge clk);
            @(posedge clk);
            wr_grant <= 1'b1;
            @(posedge clk);
            wr_grant <= 1'b0;
        end
    endtask

    // A write that the model does not expect must stay off the bus
    task automatic expect_no_write();
        logic seen;
        seen = 1'b0;
        repeat (10)
        begin
            @(negedge clk);
            seen = seen | wr_req;
        end
        if (seen)
        begin
            $display("Unexpected write request within 10 cycles, before %0t", $time);
            other_errors++;
        end
    endtask

    // Poll reads are granted and answered here alongside the writes
    initial
    begin : read_responder
        int delay;
        t_line line;
        wait (resetb);
        forever
        begin
            @(negedge clk);
            if (rd_req && !rd_hold)
            begin
                if (rd_addr !== t_line_addr'(expected_addr(BASE, 4)))
                begin
                    $display("[FAIL] %0t rd_addr expected %h actual %h", $time,
                             expected_addr(BASE, 4), rd_addr);
                    mismatches++;
                end
                if (rd_out_tag !== TAG_STATUS_POLL)
                begin
                    $display("[FAIL] %0t rd_out_tag expected %0d actual %0d", $time,
                             TAG_STATUS_POLL, rd_out_tag);
                    mismatches++;
                end
                delay = int'(take_bits(3));
                repeat (delay) @(posedge clk);
                @(posedge clk);
                rd_grant <= 1'b1;
                @(posedge clk);
                rd_grant <= 1'b0;
                // Full random words so that the pointer slices are exercised too
                line = '0;
                line[31:0]  = 32'(take_bits(32));
                line[63:32] = 32'(take_bits(32));
                rd_valid <= 1'b1;
                rd_tag   <= TAG_STATUS_POLL;
                rd_data  <= line;
                @(posedge clk);
                rd_valid <= 1'b0;
                last_newest = line[FH_BITS-1:0];
                last_oldest = line[32 +: TH_BITS];
                @(negedge clk);
                if (polled_newest !== last_newest)
                begin
                    $display("[FAIL] %0t polled_newest expected %h actual %h", $time,
                             last_newest, polled_newest);
                    mismatches++;
                end
                if (polled_oldest !== last_oldest)
                begin
                    $display("[FAIL] %0t polled_oldest expected %h actual %h", $time,
                             last_oldest, polled_oldest);
                    mismatches++;
                end
                polls_checked++;
            end
        end
    end

    // The compare process samples mid-cycle while the granted line is still driven
    always @(negedge clk)
    begin
        if (resetb && wr_grant)
        begin
            writes_checked++;
            if (!wr_req)
            begin
                $display("Write grant at %0t found no pending write request", $time);
                other_errors++;
            end
            if (wr_addr !== exp_addr)
            begin
                $display("[FAIL] %0t wr_addr expected %h actual %h", $time, exp_addr, wr_addr);
                mismatches++;
            end
            if (wr_data !== exp_line)
            begin
                $display("[FAIL] %0t wr_data expected %h actual %h", $time, exp_line, wr_data);
                mismatches++;
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin : stimulus
        logic [FH_BITS-1:0] new_from;
        logic [TH_BITS-1:0] new_to;
        logic [FH_BITS-1:0] written_from;
        logic [TH_BITS-1:0] written_to;
        logic [63:0] rsp;
        lfsr = 16'd19037;
        mismatches = 0;
        other_errors = 0;
        writes_checked = 0;
        polls_checked = 0;
        rd_hold = 1'b0;
        resetb = 1'b0;
        dsm_base = BASE;
        dsm_base_valid = 1'b0;
        enable_test = 1'b0;
        debug_trigger = DBG_NONE;
        sreg_rsp_valid = 1'b0;
        sreg_rsp = '0;
        dbg_from_host = '0;
        dbg_to_host = '0;
        dbg_tester = '0;
        from_host_oldest_read = '0;
        to_host_next_write = '0;
        rd_grant = 1'b0;
        rd_valid = 1'b0;
        rd_tag = TAG_OTHER;
        rd_data = '0;
        wr_grant = 1'b0;
        last_newest = '0;
        last_oldest = '0;
        written_from = '0;
        written_to = '0;
        repeat (2) @(posedge clk);
        resetb <= 1'b1;

        // Neither request may rise before the host has given a DSM base
        @(negedge clk);
        if (rd_req !== 1'b0)
        begin
            $display("[FAIL] %0t rd_req expected 0 actual %b", $time, rd_req);
            mismatches++;
        end
        if (wr_req !== 1'b0)
        begin
            $display("[FAIL] %0t wr_req expected 0 actual %b", $time, wr_req);
            mismatches++;
        end

        @(posedge clk);
        dsm_base_valid <= 1'b1;
        dbg_from_host <= 32'(take_bits(32));
        dbg_to_host <= 32'(take_bits(32));
        dbg_tester <= 32'(take_bits(32));

        // The device ID line goes out first
        grant_write(t_line_addr'(expected_addr(BASE, 0)), device_id_line());

        // Random pointer moves where half of them leave the to-host pointer alone
        for (int i = 0; i < NUM_PTR_MOVES; i++)
        begin
            new_from = FH_BITS'(take_bits(FH_BITS));
            new_to = take_bits(1) != 64'd0 ? TH_BITS'(take_bits(TH_BITS)) : written_to;
            @(posedge clk);
            from_host_oldest_read <= new_from;
            to_host_next_write <= new_to;
            if (fifo_write_due(new_from, new_to, written_from, written_to))
            begin
                grant_write(t_line_addr'(expected_addr(BASE, 3)), fifo_line(new_from, new_to));
                written_from = new_from;
                written_to = new_to;
            end
            else
            begin
                expect_no_write();
            end
        end

        // Debug dumps with polling paused before the polled pointer dump
        for (int k = 1; k <= NUM_DEBUG_IDX; k++)
        begin
            if (k == 4)
            begin
                rd_hold = 1'b1;
                repeat (20) @(posedge clk);
            end
            @(posedge clk);
            debug_trigger <= t_debug_idx'(3'(k));
            @(posedge clk);
            debug_trigger <= DBG_NONE;
            grant_write(t_line_addr'(expected_addr(BASE, 2)),
                        debug_line(3'(k), debug_source(3'(k), dbg_from_host, dbg_to_host,
                                                       dbg_tester, last_newest, last_oldest)));
        end
        rd_hold = 1'b0;

        // Status register responses
        repeat (NUM_SREG_RSPS)
        begin
            rsp = take_bits(64);
            @(posedge clk);
            sreg_rsp <= rsp;
            sreg_rsp_valid <= 1'b1;
            @(posedge clk);
            sreg_rsp_valid <= 1'b0;
            grant_write(t_line_addr'(expected_addr(BASE, 1)), sreg_line(rsp));
        end

        // A test start repeats the device ID line
        repeat (NUM_TEST_STARTS)
        begin
            @(posedge clk);
            enable_test <= 1'b1;
            @(posedge clk);
            enable_test <= 1'b0;
            grant_write(t_line_addr'(expected_addr(BASE, 0)), device_id_line());
        end

        repeat (20) @(posedge clk);
        if (polls_checked == 0)
        begin
            $display("No poll read of line 4 was ever completed");
            other_errors++;
        end
        $display("Closing counts: %0d value mismatches, %0d other errors, %0d writes, %0d polls",
                 mismatches, other_errors, writes_checked, polls_checked);
        if (mismatches == 0 && other_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog for a run that stalls
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("Closing counts: %0d value mismatches, %0d other errors, %0d writes, %0d polls",
                 mismatches, other_errors + 1, writes_checked, polls_checked);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- src/status_manager_top.sv
// Status manager top level: poll reader, credit tracker and write sequencer
`timescale 1ns/10ps

module status_manager_top
    import dsm_pkg::*, status_pkg::*;
#(
    parameter int FROM_HOST_IDX_BITS = 9,
    parameter int TO_HOST_IDX_BITS   = 9
)
(
    input  logic                          clk,
    input  logic                          resetb,

    // CSR side
    input  t_line_addr                    dsm_base,
    input  logic                          dsm_base_valid,
    input  logic                          enable_test,
    input  t_debug_idx                    debug_trigger,
    input  logic                          sreg_rsp_valid,
    input  logic [63:0]                   sreg_rsp,

    // Debug sources and local FIFO pointers
    input  t_debug_word                   dbg_from_host,
    input  t_debug_word                   dbg_to_host,
    input  t_debug_word                   dbg_tester,
    input  logic [FROM_HOST_IDX_BITS-1:0] from_host_oldest_read,
    input  logic [TO_HOST_IDX_BITS-1:0]   to_host_next_write,

    // Read channel to the memory arbiter
    output logic                          rd_req,
    output t_line_addr                    rd_addr,
    output t_read_tag                     rd_out_tag,
    input  logic                          rd_grant,
    input  logic                          rd_valid,
    input  t_read_tag                     rd_tag,
    input  t_line                         rd_data,

    // Write channel to the memory arbiter
    output logic                          wr_req,
    output t_line_addr                    wr_addr,
    output t_line                         wr_data,
    input  logic                          wr_grant,

    // Host FIFO pointers as last polled
    output logic [FROM_HOST_IDX_BITS-1:0] polled_newest,
    output logic [TO_HOST_IDX_BITS-1:0]   polled_oldest
);

    fifo_status_if #(
        .FROM_HOST_IDX_BITS (FROM_HOST_IDX_BITS),
        .TO_HOST_IDX_BITS   (TO_HOST_IDX_BITS)
    ) fifo_status ();

    dsm_poll_reader #(
        .FROM_HOST_IDX_BITS (FROM_HOST_IDX_BITS),
        .TO_HOST_IDX_BITS   (TO_HOST_IDX_BITS)
    ) reader_i (
        .clk            (clk),
        .resetb         (resetb),
        .dsm_base       (dsm_base),
        .dsm_base_valid (dsm_base_valid),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_out_tag     (rd_out_tag),
        .rd_grant       (rd_grant),
        .rd_valid       (rd_valid),
        .rd_tag         (rd_tag),
        .rd_data        (rd_data),
        .polled_newest  (polled_newest),
        .polled_oldest  (polled_oldest)
    );

    fifo_credit_tracker #(
        .FROM_HOST_IDX_BITS (FROM_HOST_IDX_BITS),
        .TO_HOST_IDX_BITS   (TO_HOST_IDX_BITS)
    ) tracker_i (
        .clk                   (clk),
        .resetb                (resetb),
        .from_host_oldest_read (from_host_oldest_read),
        .to_host_next_write    (to_host_next_write),
        .fifo                  (fifo_status.tracker)
    );

    dsm_write_sequencer #(
        .FROM_HOST_IDX_BITS (FROM_HOST_IDX_BITS),
        .TO_HOST_IDX_BITS   (TO_HOST_IDX_BITS)
    ) sequencer_i (
        .clk            (clk),
        .resetb         (resetb),
        .dsm_base       (dsm_base),
        .dsm_base_valid (dsm_base_valid),
        .enable_test    (enable_test),
        .debug_trigger  (debug_trigger),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp       (sreg_rsp),
        .dbg_from_host  (dbg_from_host),
        .dbg_to_host    (dbg_to_host),
        .dbg_tester     (dbg_tester),
        .polled_newest  (polled_newest),
        .polled_oldest  (polled_oldest),
        .fifo           (fifo_status.sequencer),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_grant       (wr_grant)
    );

endmodule

//--- src/dsm_write_sequencer.sv
// Writer FSM that picks, addresses and requests each DSM line write
`timescale 1ns/10ps

module dsm_write_sequencer
    import dsm_pkg::*, status_pkg::*;
#(
    parameter int FROM_HOST_IDX_BITS = 9,
    parameter int TO_HOST_IDX_BITS   = 9
)
(
    input  logic                          clk,
    input  logic                          resetb,

    input  t_line_addr                    dsm_base,
    input  logic                          dsm_base_valid,

    input  logic                          enable_test,
    input  t_debug_idx                    debug_trigger,
    input  logic                          sreg_rsp_valid,
    input  logic [63:0]                   sreg_rsp,

    input  t_debug_word                   dbg_from_host,
    input  t_debug_word                   dbg_to_host,
    input  t_debug_word                   dbg_tester,

    input  logic [FROM_HOST_IDX_BITS-1:0] polled_newest,
    input  logic [TO_HOST_IDX_BITS-1:0]   polled_oldest,

    fifo_status_if.sequencer              fifo,

    output logic                          wr_req,
    output t_line_addr                    wr_addr,
    output t_line                         wr_data,
    input  logic                          wr_grant
);

    t_writer_state state;
    t_writer_state state_next;

    // Captured request payloads
    t_debug_idx    dbg_idx;
    logic [63:0]   sreg_rsp_q;

    t_debug_word   dbg_word;
    t_dsm_offset   offset;

    // ======================================================================
    // Writer FSM
    // ======================================================================

    // Only one write is in flight at a time
    // While a line is pending, new triggers can still retarget the state
    always_comb
    begin
        state_next = state;
        if (wr_grant)
        begin
            state_next = WR_IDLE;
        end
        else if (enable_test)
        begin
            // A new test run announces itself with the device ID line again
            state_next = WR_INIT;
        end
        else if (debug_trigger != DBG_NONE)
        begin
            state_next = WR_DEBUG;
        end
        else if (sreg_rsp_valid)
        begin
            state_next = WR_SREG;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= WR_INIT;
        end
        else
        begin
            state <= state_next;
        end
    end

    // The host may not issue a new debug request before the last one is written
    always_ff @(posedge clk)
    begin
        if (debug_trigger != DBG_NONE)
        begin
            dbg_idx <= debug_trigger;
        end
        if (sreg_rsp_valid)
        begin
            sreg_rsp_q <= sreg_rsp;
        end
    end

    // Debug source selected by the captured index
    always_comb
    begin
        case (dbg_idx)
            DBG_FROM_HOST: dbg_word = dbg_from_host;
            DBG_TO_HOST:   dbg_word = dbg_to_host;
            DBG_TESTER:    dbg_word = dbg_tester;
            // Our own view of the host pointers, newest in the low half
            DBG_POLLED:    dbg_word = {16'(polled_oldest), 16'(polled_newest)};
            default:       dbg_word = '0;
        endcase
    end

    // ======================================================================
    // Line selection
    // ======================================================================

    always_comb
    begin
        wr_data = '0;
        case (state)
            WR_IDLE:
            begin
                // Idle time is spent on FIFO pointer updates
                offset                          = OFS_FIFO_STATE;
                wr_data[0 +: WORD_BITS]         = WORD_BITS'(fifo.from_host_idx);
                wr_data[WORD_BITS +: WORD_BITS] = WORD_BITS'(fifo.to_host_idx);
            end
            WR_DEBUG:
            begin
                offset                          = OFS_DEBUG_RSP;
                wr_data[0 +: WORD_BITS]         = WORD_BITS'(dbg_idx);
                wr_data[WORD_BITS +: WORD_BITS] = dbg_word;
            end
            WR_SREG:
            begin
                // The top bit tells the host that the response has landed
                offset                 = OFS_SREG_RSP;
                wr_data[63:0]          = sreg_rsp_q;
                wr_data[LINE_BITS-1]   = 1'b1;
            end
            default:
            begin
                // Device ID followed by the index ranges of both FIFOs
                offset                              = OFS_DEVICE_ID;
                wr_data[0 +: 4*WORD_BITS]           = DEVICE_ID;
                wr_data[4*WORD_BITS +: WORD_BITS]   = WORD_BITS'({FROM_HOST_IDX_BITS{1'b1}});
                wr_data[5*WORD_BITS +: WORD_BITS]   = WORD_BITS'({TO_HOST_IDX_BITS{1'b1}});
            end
        endcase
    end

    assign wr_addr = dsm_line_addr(dsm_base, offset);

    // Nothing but pointer updates are sent from idle
    assign wr_req = (state == WR_IDLE) ? fifo.need_update : dsm_base_valid;

    assign fifo.taken = (state == WR_IDLE) && fifo.need_update && wr_grant;

endmodule

//--- src/fifo_credit_tracker.sv
// Credit tracker: registers local FIFO pointers and flags when line 3 must be rewritten
`timescale 1ns/10ps

module fifo_credit_tracker
#(
    parameter int FROM_HOST_IDX_BITS = 9,
    parameter int TO_HOST_IDX_BITS   = 9
)
(
    input  logic                          clk,
    input  logic                          resetb,

    input  logic [FROM_HOST_IDX_BITS-1:0] from_host_oldest_read,
    input  logic [TO_HOST_IDX_BITS-1:0]   to_host_next_write,

    fifo_status_if.tracker                fifo
);

    // Only this bit of the from-host pointer is watched
    // Credit is returned every eighth of the ring instead of every line
    localparam int MONITOR_BIT = FROM_HOST_IDX_BITS - 3;

    // Values the host last saw in line 3
    logic [FROM_HOST_IDX_BITS-1:0] from_host_written;
    logic [TO_HOST_IDX_BITS-1:0]   to_host_written;

    logic                          update_due;

    // ======================================================================
    // Input registers
    // ======================================================================

    // One register stage breaks the path from the FIFO pointer logic
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            fifo.from_host_idx <= '0;
            fifo.to_host_idx   <= '0;
        end
        else
        begin
            fifo.from_host_idx <= from_host_oldest_read;
            fifo.to_host_idx   <= to_host_next_write;
        end
    end

    // ======================================================================
    // Update decision
    // ======================================================================

    // Any move of the to-host pointer matters to the host right away
    assign update_due = (fifo.to_host_idx != to_host_written) ||
                        (fifo.from_host_idx[MONITOR_BIT] != from_host_written[MONITOR_BIT]);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            fifo.need_update  <= 1'b0;
            from_host_written <= '0;
            to_host_written   <= '0;
        end
        else if (fifo.need_update)
        begin
            // Wait for the sequencer to get the write through
            if (fifo.taken)
            begin
                fifo.need_update  <= 1'b0;
                from_host_written <= fifo.from_host_idx;
                to_host_written   <= fifo.to_host_idx;
            end
        end
        else
        begin
            fifo.need_update <= update_due;
        end
    end

endmodule

//--- src/dsm_poll_reader.sv
// Poll reader FSM for DSM line 4, capturing the host FIFO pointers
`timescale 1ns/10ps

module dsm_poll_reader
    import dsm_pkg::*, status_pkg::*;
#(
    parameter int FROM_HOST_IDX_BITS = 9,
    parameter int TO_HOST_IDX_BITS   = 9
)
(
    input  logic                          clk,
    input  logic                          resetb,

    input  t_line_addr                    dsm_base,
    input  logic                          dsm_base_valid,

    output logic                          rd_req,
    output t_line_addr                    rd_addr,
    output t_read_tag                     rd_out_tag,
    input  logic                          rd_grant,

    input  logic                          rd_valid,
    input  t_read_tag                     rd_tag,
    input  t_line                         rd_data,

    output logic [FROM_HOST_IDX_BITS-1:0] polled_newest,
    output logic [TO_HOST_IDX_BITS-1:0]   polled_oldest
);

    t_reader_state state;
    logic          poll_rsp;

    // Only a tagged response that we are waiting for counts
    // A stray response while polling is dropped
    assign poll_rsp = (state == RD_WAIT) && rd_valid && (rd_tag == TAG_STATUS_POLL);

    // The request never changes, only whether it is raised
    assign rd_addr    = dsm_line_addr(dsm_base, OFS_POLL_STATE);
    assign rd_out_tag = TAG_STATUS_POLL;

    // Hold the read request until the arbiter grants it
    // Nothing goes out before the host has given us a DSM base
    assign rd_req = (state == RD_POLL) && dsm_base_valid;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state         <= RD_POLL;
            polled_newest <= '0;
            polled_oldest <= '0;
        end
        else
        begin
            case (state)
                RD_POLL:
                begin
                    if (rd_grant)
                    begin
                        state <= RD_WAIT;
                    end
                end
                default:
                begin
                    if (poll_rsp)
                    begin
                        state <= RD_POLL;
                    end
                end
            endcase

            // Word 0 is the newest line the host filled in the from-host FIFO
            // Word 1 is the oldest line it has read, i.e. our write credit
            if (poll_rsp)
            begin
                polled_newest <= rd_data[0 +: FROM_HOST_IDX_BITS];
                polled_oldest <= rd_data[WORD_BITS +: TO_HOST_IDX_BITS];
            end
        end
    end

endmodule

//--- src/fifo_status_if.sv
// Interface for the pending FIFO pointer update between credit tracker and write sequencer
`timescale 1ns/10ps

interface fifo_status_if
#(
    parameter int FROM_HOST_IDX_BITS = 9,
    parameter int TO_HOST_IDX_BITS   = 9
);

    // A line 3 write is wanted with the pointers below
    logic                          need_update;
    logic [FROM_HOST_IDX_BITS-1:0] from_host_idx;
    logic [TO_HOST_IDX_BITS-1:0]   to_host_idx;

    // Single-cycle pulse when the line 3 write was granted
    logic                          taken;

    modport tracker (output need_update, output from_host_idx, output to_host_idx,
                     input taken);

    modport sequencer (input need_update, input from_host_idx, input to_host_idx,
                       output taken);

endinterface

//--- src/status_pkg.sv
// Status manager types: writer and reader states, debug dump index, debug word

package status_pkg;

    // Writer FSM states
    // WR_INIT sends the device ID line and is also reentered when a test starts
    typedef enum logic [1:0]
    {
        WR_INIT,
        WR_IDLE,
        WR_DEBUG,
        WR_SREG
    } t_writer_state;

    // Poll reader states
    typedef enum logic
    {
        RD_POLL,
        RD_WAIT
    } t_reader_state;

    // Debug dump selector written by the host through a CSR
    // Zero means that no dump is requested
    typedef enum logic [2:0]
    {
        DBG_NONE      = 3'd0,
        DBG_FROM_HOST = 3'd1,
        DBG_TO_HOST   = 3'd2,
        DBG_TESTER    = 3'd3,
        DBG_POLLED    = 3'd4
    } t_debug_idx;

    // One word of debug state from a client block
    typedef logic [31:0] t_debug_word;

endpackage

//--- src/dsm_pkg.sv
// Device status memory layout: line and word widths, line address type, line offsets, device ID, read tag

package dsm_pkg;

    // ======================================================================
    // Cache line geometry
    // ======================================================================

    // One DSM write moves a whole cache line of 16 words
    localparam int LINE_BITS = 512;
    localparam int WORD_BITS = 32;

    typedef logic [LINE_BITS-1:0] t_line;

    // Host addresses are counted in cache lines, not bytes
    typedef logic [31:0] t_line_addr;

    // Line offsets from the DSM base, which the host driver must agree with
    typedef enum logic [2:0]
    {
        OFS_DEVICE_ID  = 3'd0,
        OFS_SREG_RSP   = 3'd1,
        OFS_DEBUG_RSP  = 3'd2,
        OFS_FIFO_STATE = 3'd3,
        OFS_POLL_STATE = 3'd4
    } t_dsm_offset;

    // Words 0 to 3 of line 0, telling the host that the FPGA side is alive
    localparam logic [127:0] DEVICE_ID = 128'h12345678_0d824272_9aeffe5f_84570612;

    // Tag that travels with a read so the response can be routed back
    typedef enum logic
    {
        TAG_OTHER       = 1'b0,
        TAG_STATUS_POLL = 1'b1
    } t_read_tag;

    // Line address of a given DSM slot
    function automatic t_line_addr dsm_line_addr(t_line_addr base, t_dsm_offset ofs);
        return base + t_line_addr'(ofs);
    endfunction

endpackage
